/* Bender.yml */
package:
  name: pitch_synth

sources:
  - verilog/synth_pitch_pkg.sv
  - verilog/note_table.sv
  - verilog/patch_regs.sv
  - verilog/key_store.sv
  - verilog/pitch_control.sv
  - verilog/pitch_synth_top.sv
  - target: simulation
    files:
      - sim/pitch_tb.sv

/* sim/pitch_tb.sv */
`timescale 1ns/1ps

module pitch_tb import synth_pitch_pkg::*; ();

    localparam int VOICES      = 8;
    localparam int V_OSC       = 4;
    localparam int NROWS       = 16;
    localparam int TIMEOUT_CYC = 40 * NROWS + 100;

    typedef struct packed {
        int voice;
        int osc;
        int key;
        int ct;
        int ft;
        int ks;
        int bct;
        int bft;
        int pr;
        int bend;
        int rnd;      // take the bend from the lfsr
        int rd_off;
        int hit;
    } row_t;

    // voice osc key  ct  ft  ks bct bft pr bend  rnd rd hit
    localparam row_t TBL [NROWS] = '{
        '{0, 0,  60,  64, 64,   0, 64,  64,  3,  8192, 0, 0, 1},
        '{1, 1,  69,  64, 64,   0, 64,  64,  3,  8192, 0, 2, 0},
        '{2, 2, 127,  64, 64,   0, 76,  64,  3,  8192, 0, 8, 1},   // up an octave
        '{3, 3, 250,  64, 64,   0, 80,  64,  3,  8192, 0, 9, 1},   // clips at 255
        '{4, 0,   5,  64, 64,   0, 40,  64,  3,  8192, 0, 3, 0},   // clips at 0
        '{5, 1,  64,  64, 64,   0, 64, 100,  3,  8192, 0, 9, 1},
        '{6, 2,  72,  64, 64,   0, 64,  20,  3,  8192, 0, 4, 0},
        '{7, 3,  48,  64, 64,   0, 64,  64,  2,     0, 1, 1, 1},
        '{0, 0,  80,  64, 64,   0, 64,  64, 12, 16383, 0, 5, 1},
        '{1, 1,  55,  64, 64,   0, 64,  64,  5,     0, 0, 6, 0},
        '{2, 2,  90,  64, 64,  37, 64,  80,  4,     0, 1, 5, 1},
        '{3, 3,  60,  60, 64,   0, 64,  64,  3,  8192, 0, 0, 1},
        '{4, 0,  70,  64, 90,   0, 64,  64,  3,  8192, 0, 1, 1},
        '{5, 1,  66,  70, 30,   0, 62,  70,  3,  9000, 0, 0, 1},
        '{6, 2,  40,   0, 127, 100, 64, 10,  7,     0, 1, 7, 0},
        '{7, 3, 200, 127,  0,   0, 64,  64,  3,  8192, 1, 8, 1}    // wraps past 24 bits
    };

    localparam logic [3:0] OFFS [5] = '{REG_CT, REG_FT, REG_KSCALE, REG_BCT, REG_BFT};

    logic                 sCLK_XVXOSC = 1'b0;
    logic                 reset_data_N;
    logic [ADR_W-1:0]     adr;
    logic [7:0]           wdata;
    logic                 write;
    logic                 read;
    logic                 osc_sel;
    logic                 com_sel;
    logic                 note_on;
    logic [2:0]           key_adr;
    logic [KEY_W-1:0]     key_val;
    logic [BEND_W-1:0]    bend;
    logic [4:0]           slot;
    logic                 slot_valid;
    logic [7:0]           rdata;
    logic                 rdata_hit;
    logic [INC_W-1:0]     osc_pitch_val;
    logic                 pitch_valid;

    int cycles = 0;
    logic [31:0] lfsr_state = 32'h84a8;
    logic [INC_W-1:0] exp_q [$];
    int iss_q [$];   // issue cycle of each slot in flight

    // mirror of the register file and key store
    int m_ct [V_OSC];
    int m_ft [V_OSC];
    int m_ks [V_OSC];
    int m_bct [V_OSC];
    int m_bft [V_OSC];
    int m_pr;
    int m_key [VOICES];

    pitch_synth_top #(.VOICES(VOICES), .V_OSC(V_OSC)) u_pitch_synth_top (
        .sCLK_XVXOSC  (sCLK_XVXOSC),   .reset_data_N (reset_data_N),
        .adr          (adr),           .wdata        (wdata),
        .write        (write),         .read         (read),
        .osc_sel      (osc_sel),       .com_sel      (com_sel),
        .note_on      (note_on),       .key_adr      (key_adr),
        .key_val      (key_val),       .bend         (bend),
        .slot         (slot),          .slot_valid   (slot_valid),
        .rdata        (rdata),         .rdata_hit    (rdata_hit),
        .osc_pitch_val(osc_pitch_val), .pitch_valid  (pitch_valid)
    );

    always #4 sCLK_XVXOSC = ~sCLK_XVXOSC;

    task automatic fail_and_stop(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_val(input string name, input logic [31:0] act, input logic [31:0] exp);
        if (act !== exp) begin
            fail_and_stop($sformatf("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, act, exp));
        end
    endtask

    always @(posedge sCLK_XVXOSC) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYC) begin
            fail_and_stop("timeout, the run went past its cycle limit");
        end
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    function automatic int abs_i(input int x);
        return (x < 0) ? -x : x;
    endfunction

    function automatic longint inc_of(input int k);
        int kc;
        kc = (k < 0) ? 0 : ((k > 255) ? 255 : k);
        return longint'(note_increment(8'(kc)));
    endfunction

    function automatic logic [INC_W-1:0] model_pitch(input int v, input int o, input int b);
        int key0;
        int step_f;
        int step_b;
        longint base_i;
        longint fine_i;
        longint tgt_i;
        longint s2;
        longint s3;
        longint s4;
        key0   = m_key[v] + m_bct[o] - 64;
        step_f = (m_bft[o] <= 64) ? -1 : 1;
        step_b = (b > 8191) ? m_pr : -m_pr;
        base_i = inc_of(key0);
        fine_i = inc_of(key0 + step_f);
        tgt_i  = inc_of(key0 + step_b);
        s2 = base_i + (((fine_i - base_i) * abs_i(m_bft[o] - 64)) >>> 6)
           + (((tgt_i - base_i) * abs_i(b - 8192)) >>> 13) + m_ks[o] * 16;
        if (m_ct[o] <= 64) begin
            s3 = s2 / (65 - m_ct[o]);
        end else begin
            s3 = s2 * (m_ct[o] - 63);
        end
        s4 = s3 + ((s3 * (m_ft[o] - 64)) >>> 10);
        return s4[INC_W-1:0];
    endfunction

    function automatic logic [7:0] mirror_val(input int o, input logic [3:0] off);
        case (off)
            REG_CT:     return 8'(m_ct[o]);
            REG_FT:     return 8'(m_ft[o]);
            REG_KSCALE: return 8'(m_ks[o]);
            REG_BCT:    return 8'(m_bct[o]);
            REG_BFT:    return 8'(m_bft[o]);
            default:    return 8'h00;
        endcase
    endfunction

    task automatic mirror_reset();
        for (int o = 0; o < V_OSC; o++) begin
            m_ct[o]  = 64;
            m_ft[o]  = 64;
            m_ks[o]  = 0;
            m_bct[o] = 64;
            m_bft[o] = 64;
        end
        for (int v = 0; v < VOICES; v++) begin
            m_key[v] = 255;
        end
        m_pr = 3;
    endtask

    task automatic reg_write(input bit com, input logic [6:0] a, input logic [7:0] d);
        @(posedge sCLK_XVXOSC);
        adr     <= a;
        wdata   <= d;
        write   <= 1'b1;
        osc_sel <= !com;
        com_sel <= com;
        @(posedge sCLK_XVXOSC);
        write   <= 1'b0;
        osc_sel <= 1'b0;
        com_sel <= 1'b0;
    endtask

    task automatic osc_write(input int o, input logic [3:0] off, input int d);
        reg_write(1'b0, {1'b0, 2'(o), off}, 8'(d));
        case (off)
            REG_CT:     m_ct[o]  = $signed(8'(d));
            REG_FT:     m_ft[o]  = $signed(8'(d));
            REG_KSCALE: m_ks[o]  = $signed(8'(d));
            REG_BCT:    m_bct[o] = $signed(8'(d));
            default:    m_bft[o] = $signed(8'(d));
        endcase
    endtask

    task automatic key_write(input int v, input int k);
        @(posedge sCLK_XVXOSC);
        note_on <= 1'b1;
        key_adr <= 3'(v);
        key_val <= 8'(k);
        @(posedge sCLK_XVXOSC);
        note_on <= 1'b0;
        m_key[v] = k;
    endtask

    task automatic read_reg(input bit com, input logic [6:0] a, input bit exp_hit,
                            input logic [7:0] exp_val);
        logic [7:0] prev;
        @(negedge sCLK_XVXOSC);
        prev = rdata;
        @(posedge sCLK_XVXOSC);
        adr     <= a;
        read    <= 1'b1;
        osc_sel <= !com;
        com_sel <= com;
        @(posedge sCLK_XVXOSC);
        read    <= 1'b0;
        osc_sel <= 1'b0;
        com_sel <= 1'b0;
        @(negedge sCLK_XVXOSC);
        check_val("rdata_hit", rdata_hit, exp_hit);
        check_val("rdata", rdata, exp_hit ? exp_val : prev);   // a miss keeps old data
        @(negedge sCLK_XVXOSC);
        check_val("rdata_hit", rdata_hit, 1'b0);
    endtask

    task automatic read_all();
        for (int o = 0; o < V_OSC; o++) begin
            for (int i = 0; i < 5; i++) begin
                read_reg(1'b0, {1'b0, 2'(o), OFFS[i]}, 1'b1, mirror_val(o, OFFS[i]));
            end
        end
        read_reg(1'b1, 7'h00, 1'b1, 8'(m_pr));
    endtask

    task automatic issue_slot(input int v, input int o, input logic [BEND_W-1:0] b);
        @(posedge sCLK_XVXOSC);
        slot       <= {3'(v), 2'(o)};
        slot_valid <= 1'b1;
        bend       <= b;
        exp_q.push_back(model_pitch(v, o, int'(b)));
        iss_q.push_back(cycles + 1);
    endtask

    task automatic slot_idle();
        @(posedge sCLK_XVXOSC);
        slot_valid <= 1'b0;
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (exp_q.size() != 0) begin
            @(posedge sCLK_XVXOSC);
            n++;
            if (n > 12) begin
                fail_and_stop("no pitch_valid arrived for an issued slot");
            end
        end
    endtask

    task automatic apply_row(input row_t r);
        logic [BEND_W-1:0] b;
        osc_write(r.osc, REG_CT, r.ct);
        osc_write(r.osc, REG_FT, r.ft);
        osc_write(r.osc, REG_KSCALE, r.ks);
        osc_write(r.osc, REG_BCT, r.bct);
        osc_write(r.osc, REG_BFT, r.bft);
        reg_write(1'b1, 7'h00, 8'(r.pr));
        m_pr = r.pr;
        key_write(r.voice, r.key);
        read_reg(1'b0, {1'b0, 2'(r.osc), 4'(r.rd_off)}, r.hit[0],
                 mirror_val(r.osc, 4'(r.rd_off)));
        b = (r.rnd != 0) ? BEND_W'(rand_bits(BEND_W)) : BEND_W'(r.bend);
        issue_slot(r.voice, r.osc, b);
        slot_idle();
        wait_drain();
    endtask

    // results come back in issue order
    always @(negedge sCLK_XVXOSC) begin
        if (reset_data_N === 1'b1 && pitch_valid === 1'b1) begin
            if (exp_q.size() == 0) begin
                fail_and_stop("pitch_valid rose with no slot in flight");
            end else begin
                check_val("pitch latency", cycles - iss_q[0], 4);
                check_val("osc_pitch_val", osc_pitch_val, exp_q[0]);
                void'(exp_q.pop_front());
                void'(iss_q.pop_front());
            end
        end
    end

    initial begin
        reset_data_N = 1'b0;
        adr          = '0;
        wdata        = '0;
        write        = 1'b0;
        read         = 1'b0;
        osc_sel      = 1'b0;
        com_sel      = 1'b0;
        note_on      = 1'b0;
        key_adr      = '0;
        key_val      = '0;
        bend         = 14'd8192;
        slot         = '0;
        slot_valid   = 1'b0;
        mirror_reset();
        repeat (2) @(posedge sCLK_XVXOSC);
        reset_data_N <= 1'b1;
        @(negedge sCLK_XVXOSC);
        check_val("rdata_hit", rdata_hit, 1'b0);
        check_val("pitch_valid", pitch_valid, 1'b0);

        read_all();
        read_reg(1'b0, 7'h02, 1'b0, 8'h00);   // hole in osc 0 window
        read_reg(1'b1, 7'h01, 1'b0, 8'h00);
        read_reg(1'b0, 7'h40, 1'b0, 8'h00);   // osc 4 does not exist

        for (int i = 0; i < NROWS; i++) begin
            apply_row(TBL[i]);
        end
        read_all();

        // four slots in flight at once
        issue_slot(3, 0, BEND_W'(rand_bits(BEND_W)));
        issue_slot(6, 1, BEND_W'(rand_bits(BEND_W)));
        issue_slot(1, 2, BEND_W'(rand_bits(BEND_W)));
        issue_slot(4, 3, BEND_W'(rand_bits(BEND_W)));
        slot_idle();
        wait_drain();

        $display("Test completed successfully");
        $finish;
    end

endmodule

/* tb.f */
verilog/synth_pitch_pkg.sv
verilog/note_table.sv
verilog/patch_regs.sv
verilog/key_store.sv
verilog/pitch_control.sv
verilog/pitch_synth_top.sv
sim/pitch_tb.sv

/* verilog/key_store.sv */
`timescale 1ns/1ps

module key_store import synth_pitch_pkg::*; #(
    parameter int VOICES = 8
) (
    input  logic                      sCLK_XVXOSC,
    input  logic                      reset_data_N,
    input  logic                      note_on,
    input  logic [V_WIDTH-1:0]        key_adr,
    input  logic [KEY_W-1:0]          key_val,
    output logic [VOICES*KEY_W-1:0]   keys
);

    localparam int V_WIDTH = (VOICES > 1) ? $clog2(VOICES) : 1;

    logic [KEY_W-1:0] key_r [VOICES];

    // FF marks a voice that has not seen a note yet
    always_ff @(posedge sCLK_XVXOSC) begin
        if (!reset_data_N) begin
            for (int v = 0; v < VOICES; v++) begin
                key_r[v] <= '1;
            end
        end else if (note_on) begin
            key_r[key_adr] <= key_val;
        end
    end

    for (genvar v = 0; v < VOICES; v++) begin : g_flat
        assign keys[v*KEY_W +: KEY_W] = key_r[v];
    end

endmodule

/* verilog/note_table.sv */
`timescale 1ns/1ps

module note_table import synth_pitch_pkg::*; (
    input  logic                 sCLK_XVXOSC,
    input  logic signed [9:0]    key_idx,
    output logic [INC_W-1:0]     increment
);

    logic [KEY_W-1:0] key_sat;

    // transposed keys can run past either end of the keyboard
    always_comb begin
        if (key_idx < 10'sd0) begin
            key_sat = '0;
        end else if (key_idx > 10'sd255) begin
            key_sat = '1;
        end else begin
            key_sat = key_idx[KEY_W-1:0];
        end
    end

    always_ff @(posedge sCLK_XVXOSC) begin
        increment <= note_increment(key_sat);
    end

endmodule

/* verilog/patch_regs.sv */
`timescale 1ns/1ps

module patch_regs import synth_pitch_pkg::*; #(
    parameter int V_OSC = 4
) (
    input  logic                 sCLK_XVXOSC,
    input  logic                 reset_data_N,
    input  logic [ADR_W-1:0]     adr,
    input  logic [7:0]           wdata,
    input  logic                 write,
    input  logic                 read,
    input  logic                 osc_sel,
    input  logic                 com_sel,
    output logic [7:0]           rdata,
    output logic                 rdata_hit,
    output logic [V_OSC*8-1:0]   osc_ct,
    output logic [V_OSC*8-1:0]   osc_ft,
    output logic [V_OSC*8-1:0]   k_scale,
    output logic [V_OSC*8-1:0]   b_ct,
    output logic [V_OSC*8-1:0]   b_ft,
    output logic [7:0]           pb_range
);

    localparam int O_WIDTH = (V_OSC > 1) ? $clog2(V_OSC) : 1;

    logic signed [7:0] ct_r  [V_OSC];   // ratio
    logic signed [7:0] ft_r  [V_OSC];   // ratio fine
    logic signed [7:0] ks_r  [V_OSC];
    logic signed [7:0] bct_r [V_OSC];   // base coarse
    logic signed [7:0] bft_r [V_OSC];   // base fine
    logic signed [7:0] pb_r;

    logic [ADR_W-5:0]   osc_num;
    logic [O_WIDTH-1:0] osc_idx;
    logic [3:0]         offs;
    logic               offs_ok;
    logic               osc_hit;
    logic               com_hit;
    logic               rd_hit;
    logic [7:0]         osc_val;

    assign osc_num = adr[ADR_W-1:4];
    assign osc_idx = osc_num[O_WIDTH-1:0];
    assign offs    = adr[3:0];
    assign osc_hit = osc_sel && (osc_num < V_OSC) && offs_ok;
    assign com_hit = com_sel && (adr == '0);   // bend range is the only common reg
    assign rd_hit  = read && (osc_hit || com_hit);

    always_comb begin
        offs_ok = 1'b1;
        osc_val = ct_r[osc_idx];
        case (offs)
            REG_CT:     osc_val = ct_r[osc_idx];
            REG_FT:     osc_val = ft_r[osc_idx];
            REG_KSCALE: osc_val = ks_r[osc_idx];
            REG_BCT:    osc_val = bct_r[osc_idx];
            REG_BFT:    osc_val = bft_r[osc_idx];
            default:    offs_ok = 1'b0;   // hole in the window
        endcase
    end

    always_ff @(posedge sCLK_XVXOSC) begin
        if (!reset_data_N) begin
            for (int i = 0; i < V_OSC; i++) begin
                ct_r[i]  <= TUNE_CENTRE;
                ft_r[i]  <= TUNE_CENTRE;
                ks_r[i]  <= '0;
                bct_r[i] <= TUNE_CENTRE;
                bft_r[i] <= TUNE_CENTRE;
            end
            pb_r <= PB_RANGE_RST;
        end else if (write && osc_hit) begin
            case (offs)
                REG_CT:     ct_r[osc_idx]  <= wdata;
                REG_FT:     ft_r[osc_idx]  <= wdata;
                REG_KSCALE: ks_r[osc_idx]  <= wdata;
                REG_BCT:    bct_r[osc_idx] <= wdata;
                REG_BFT:    bft_r[osc_idx] <= wdata;
                default:    ;
            endcase
        end else if (write && com_hit) begin
            pb_r <= wdata;
        end
    end

    always_ff @(posedge sCLK_XVXOSC) begin
        if (!reset_data_N) begin
            rdata_hit <= 1'b0;
        end else begin
            rdata_hit <= rd_hit;   // one cycle pulse
        end
    end

    always_ff @(posedge sCLK_XVXOSC) begin
        if (rd_hit) begin
            rdata <= osc_hit ? osc_val : pb_r;
        end
    end

    for (genvar i = 0; i < V_OSC; i++) begin : g_flat
        assign osc_ct[i*8 +: 8]  = ct_r[i];
        assign osc_ft[i*8 +: 8]  = ft_r[i];
        assign k_scale[i*8 +: 8] = ks_r[i];
        assign b_ct[i*8 +: 8]    = bct_r[i];
        assign b_ft[i*8 +: 8]    = bft_r[i];
    end

    assign pb_range = pb_r;

endmodule

/* verilog/pitch_control.sv */
`timescale 1ns/1ps

module pitch_control import synth_pitch_pkg::*; #(
    parameter int VOICES = 8,
    parameter int V_OSC  = 4
) (
    input  logic                           sCLK_XVXOSC,
    input  logic                           reset_data_N,
    input  logic [V_WIDTH+O_WIDTH-1:0]     slot,
    input  logic                           slot_valid,
    input  logic [VOICES*KEY_W-1:0]        keys,
    input  logic [V_OSC*8-1:0]             osc_ct,
    input  logic [V_OSC*8-1:0]             osc_ft,
    input  logic [V_OSC*8-1:0]             k_scale,
    input  logic [V_OSC*8-1:0]             b_ct,
    input  logic [V_OSC*8-1:0]             b_ft,
    input  logic [7:0]                     pb_range,
    input  logic [BEND_W-1:0]              bend,
    output logic [INC_W-1:0]               osc_pitch_val,
    output logic                           pitch_valid
);

    localparam int V_WIDTH = (VOICES > 1) ? $clog2(VOICES) : 1;
    localparam int O_WIDTH = (V_OSC > 1) ? $clog2(V_OSC) : 1;

    logic signed [7:0] ct_a  [V_OSC];
    logic signed [7:0] ft_a  [V_OSC];
    logic signed [7:0] ks_a  [V_OSC];
    logic signed [7:0] bct_a [V_OSC];
    logic signed [7:0] bft_a [V_OSC];

    for (genvar i = 0; i < V_OSC; i++) begin : g_unpack
        assign ct_a[i]  = osc_ct[i*8 +: 8];
        assign ft_a[i]  = osc_ft[i*8 +: 8];
        assign ks_a[i]  = k_scale[i*8 +: 8];
        assign bct_a[i] = b_ct[i*8 +: 8];
        assign bft_a[i] = b_ft[i*8 +: 8];
    end

    // stage 1, table keys
    logic [V_WIDTH-1:0] vx;
    logic [O_WIDTH-1:0] ox;
    logic [KEY_W-1:0]   cur_key;
    logic               ft_down;
    logic               bend_up;
    logic signed [9:0]  base_key;
    logic signed [9:0]  fine_key;
    logic signed [9:0]  tgt_key;

    assign vx      = slot[V_WIDTH+O_WIDTH-1:O_WIDTH];
    assign ox      = slot[O_WIDTH-1:0];
    assign cur_key = keys[vx*KEY_W +: KEY_W];
    assign ft_down = (bft_a[ox] <= 8'sd64);
    assign bend_up = (bend > 14'd8191);

    assign base_key = $signed({2'b00, cur_key}) + 10'(bct_a[ox]) - 10'sd64;
    assign fine_key = ft_down ? base_key - 10'sd1 : base_key + 10'sd1;
    assign tgt_key  = bend_up ? base_key + 10'(signed'(pb_range))
                              : base_key - 10'(signed'(pb_range));

    logic [INC_W-1:0] base_inc;
    logic [INC_W-1:0] fine_inc;
    logic [INC_W-1:0] tgt_inc;

    note_table u_base_tbl (.sCLK_XVXOSC(sCLK_XVXOSC), .key_idx(base_key), .increment(base_inc));
    note_table u_fine_tbl (.sCLK_XVXOSC(sCLK_XVXOSC), .key_idx(fine_key), .increment(fine_inc));
    note_table u_tgt_tbl  (.sCLK_XVXOSC(sCLK_XVXOSC), .key_idx(tgt_key), .increment(tgt_inc));

    logic [O_WIDTH-1:0] ox_d1;
    logic [O_WIDTH-1:0] ox_d2;
    logic [O_WIDTH-1:0] ox_d3;
    logic [BEND_W-1:0]  bend_d1;
    logic               v1;
    logic               v2;
    logic               v3;

    always_ff @(posedge sCLK_XVXOSC) begin
        ox_d1   <= ox;
        ox_d2   <= ox_d1;
        ox_d3   <= ox_d2;
        bend_d1 <= bend;   // same wheel sample as the target key
    end

    always_ff @(posedge sCLK_XVXOSC) begin
        if (!reset_data_N) begin
            v1          <= 1'b0;
            v2          <= 1'b0;
            v3          <= 1'b0;
            pitch_valid <= 1'b0;
        end else begin
            v1          <= slot_valid;
            v2          <= v1;
            v3          <= v2;
            pitch_valid <= v3;
        end
    end

    // stage 2, fine tune, bend and key scaling
    logic signed [8:0]  bft_off;
    logic [8:0]         ft_mag;
    logic signed [14:0] bend_off;
    logic [14:0]        bend_mag;
    logic signed [24:0] ft_diff;
    logic signed [24:0] bd_diff;
    logic signed [34:0] ft_prod;
    logic signed [40:0] bd_prod;
    logic signed [11:0] ks_term;
    logic signed [40:0] s2_sum;
    logic signed [31:0] s2_val;

    assign bft_off  = 9'(bft_a[ox_d1]) - 9'sd64;
    assign ft_mag   = (bft_off < 9'sd0) ? 9'(-bft_off) : 9'(bft_off);
    assign bend_off = $signed({1'b0, bend_d1}) - 15'sd8192;
    assign bend_mag = (bend_off < 15'sd0) ? 15'(-bend_off) : 15'(bend_off);
    assign ft_diff  = $signed({1'b0, fine_inc}) - $signed({1'b0, base_inc});
    assign bd_diff  = $signed({1'b0, tgt_inc}) - $signed({1'b0, base_inc});
    assign ft_prod  = 35'(ft_diff) * 35'($signed({1'b0, ft_mag}));
    assign bd_prod  = 41'(bd_diff) * 41'($signed({1'b0, bend_mag}));
    assign ks_term  = $signed({ks_a[ox_d1], 4'b0000});   // k_scale x 16

    assign s2_sum = 41'($signed({1'b0, base_inc})) + 41'(ft_prod >>> 6)
                  + (bd_prod >>> 13) + 41'(ks_term);

    always_ff @(posedge sCLK_XVXOSC) begin
        s2_val <= s2_sum[31:0];
    end

    // stage 3, oscillator ratio
    logic signed [8:0]  ratio_div;
    logic signed [8:0]  ratio_mul;
    logic signed [39:0] s3_next;
    logic signed [39:0] s3_val;

    assign ratio_div = 9'sd65 - 9'(ct_a[ox_d2]);   // 1 at centre
    assign ratio_mul = 9'(ct_a[ox_d2]) - 9'sd63;

    always_comb begin
        if (ct_a[ox_d2] <= 8'sd64) begin
            s3_next = 40'(s2_val) / 40'(ratio_div);
        end else begin
            s3_next = 40'(s2_val) * 40'(ratio_mul);
        end
    end

    always_ff @(posedge sCLK_XVXOSC) begin
        s3_val <= s3_next;
    end

    // stage 4, oscillator fine tune
    logic signed [8:0]  oft_off;
    logic signed [49:0] oft_prod;
    logic signed [49:0] s4_sum;

    assign oft_off  = 9'(ft_a[ox_d3]) - 9'sd64;
    assign oft_prod = 50'(s3_val) * 50'(oft_off);
    assign s4_sum   = 50'(s3_val) + (oft_prod >>> 10);

    always_ff @(posedge sCLK_XVXOSC) begin
        osc_pitch_val <= s4_sum[INC_W-1:0];   // wraps like the phase accumulator
    end

endmodule

/* verilog/pitch_synth_top.sv */
`timescale 1ns/1ps

module pitch_synth_top import synth_pitch_pkg::*; #(
    parameter int VOICES = 8,
    parameter int V_OSC  = 4
) (
    input  logic                           sCLK_XVXOSC,
    input  logic                           reset_data_N,
    input  logic [ADR_W-1:0]               adr,
    input  logic [7:0]                     wdata,
    input  logic                           write,
    input  logic                           read,
    input  logic                           osc_sel,
    input  logic                           com_sel,
    input  logic                           note_on,
    input  logic [V_WIDTH-1:0]             key_adr,
    input  logic [KEY_W-1:0]               key_val,
    input  logic [BEND_W-1:0]              bend,
    input  logic [V_WIDTH+O_WIDTH-1:0]     slot,
    input  logic                           slot_valid,
    output logic [7:0]                     rdata,
    output logic                           rdata_hit,
    output logic [INC_W-1:0]               osc_pitch_val,
    output logic                           pitch_valid
);

    localparam int V_WIDTH = (VOICES > 1) ? $clog2(VOICES) : 1;
    localparam int O_WIDTH = (V_OSC > 1) ? $clog2(V_OSC) : 1;

    logic [V_OSC*8-1:0]       osc_ct;
    logic [V_OSC*8-1:0]       osc_ft;
    logic [V_OSC*8-1:0]       k_scale;
    logic [V_OSC*8-1:0]       b_ct;
    logic [V_OSC*8-1:0]       b_ft;
    logic [7:0]               pb_range;
    logic [VOICES*KEY_W-1:0]  keys;

    patch_regs #(.V_OSC(V_OSC)) u_patch_regs (
        .sCLK_XVXOSC (sCLK_XVXOSC),  .reset_data_N(reset_data_N),
        .adr         (adr),          .wdata       (wdata),
        .write       (write),        .read        (read),
        .osc_sel     (osc_sel),      .com_sel     (com_sel),
        .rdata       (rdata),        .rdata_hit   (rdata_hit),
        .osc_ct      (osc_ct),       .osc_ft      (osc_ft),
        .k_scale     (k_scale),      .b_ct        (b_ct),
        .b_ft        (b_ft),         .pb_range    (pb_range)
    );

    key_store #(.VOICES(VOICES)) u_key_store (
        .sCLK_XVXOSC (sCLK_XVXOSC),  .reset_data_N(reset_data_N),
        .note_on     (note_on),      .key_adr     (key_adr),
        .key_val     (key_val),      .keys        (keys)
    );

    pitch_control #(.VOICES(VOICES), .V_OSC(V_OSC)) u_pitch_control (
        .sCLK_XVXOSC (sCLK_XVXOSC),  .reset_data_N (reset_data_N),
        .slot        (slot),         .slot_valid   (slot_valid),
        .keys        (keys),         .osc_ct       (osc_ct),
        .osc_ft      (osc_ft),       .k_scale      (k_scale),
        .b_ct        (b_ct),         .b_ft         (b_ft),
        .pb_range    (pb_range),     .bend         (bend),
        .osc_pitch_val(osc_pitch_val), .pitch_valid(pitch_valid)
    );

endmodule

/* verilog/synth_pitch_pkg.sv */
package synth_pitch_pkg;

    localparam int KEY_W  = 8;
    localparam int INC_W  = 24;
    localparam int BEND_W = 14;   // wheel centre is 8192
    localparam int ADR_W  = 7;

    localparam logic [7:0] TUNE_CENTRE  = 8'h40;
    localparam logic [7:0] PB_RANGE_RST = 8'd3;   // semitones

    // offsets inside a 16 byte oscillator window
    localparam logic [3:0] REG_CT     = 4'd0;
    localparam logic [3:0] REG_FT     = 4'd1;
    localparam logic [3:0] REG_KSCALE = 4'd5;
    localparam logic [3:0] REG_BCT    = 4'd8;
    localparam logic [3:0] REG_BFT    = 4'd9;

    // top octave, equal temperament
    localparam logic [INC_W-1:0] SEMI_TABLE [12] = '{
        24'd8388608, 24'd8887420, 24'd9415894, 24'd9975792,
        24'd10568984, 24'd11197448, 24'd11863285, 24'd12568711,
        24'd13316085, 24'd14107901, 24'd14946800, 24'd15835583
    };

    function automatic logic [INC_W-1:0] note_increment(input logic [KEY_W-1:0] key);
        int unsigned oct;
        int unsigned shift;
        oct   = key / 12;
        shift = (oct > 21) ? 0 : 21 - oct;   // keys 252..255 sit in the top octave
        return SEMI_TABLE[key % 12] >> shift;
    endfunction

endpackage
